// File: design/alu_unit.sv
`timescale 1ns/10ps

module alu_unit
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  op1_t  op1,
  input  op2_t  op2,
  input  imm_t  imm,
  input  data_t rs_val,
  input  data_t rt_val,
  output logic  alu_valid,
  output data_t alu_result,
  output logic  alu_wr_reg
);

  data_t imm_sx;     // Sign-extended immediate
  data_t result_n;   // Combinational ALU output
  logic  wr_reg_n;

  assign imm_sx = {{(DATA_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm};

  // Register-register and register-immediate operations
  always_comb
  begin
    result_n = '0;
    if (op1 == OP1_ALUR)
    begin
      case (op2)
        OP2_EQ   : result_n = {{(DATA_BITS-1){1'b0}}, rs_val == rt_val};
        OP2_LT   : result_n = {{(DATA_BITS-1){1'b0}}, rs_val < rt_val};   // Signed
        OP2_LE   : result_n = {{(DATA_BITS-1){1'b0}}, rs_val <= rt_val};
        OP2_NE   : result_n = {{(DATA_BITS-1){1'b0}}, rs_val != rt_val};
        OP2_ADD  : result_n = rs_val + rt_val;
        OP2_AND  : result_n = rs_val & rt_val;
        OP2_OR   : result_n = rs_val | rt_val;
        OP2_XOR  : result_n = rs_val ^ rt_val;
        OP2_SUB  : result_n = rs_val - rt_val;
        OP2_NAND : result_n = ~(rs_val & rt_val);
        OP2_NOR  : result_n = ~(rs_val | rt_val);
        OP2_NXOR : result_n = ~(rs_val ^ rt_val);
        OP2_RSHF : result_n = rs_val >>> rt_val;  // Sign fill
        OP2_LSHF : result_n = rs_val << rt_val;   // Zero fill
        default  : result_n = '0;
      endcase
    end
    else
    begin
      case (op1)
        OP1_LW, OP1_SW, OP1_ADDI : result_n = rs_val + imm_sx;  // Base plus offset
        OP1_ANDI : result_n = rs_val & imm_sx;
        OP1_ORI  : result_n = rs_val | imm_sx;
        OP1_XORI : result_n = rs_val ^ imm_sx;
        default  : result_n = '0;   // Branches, JAL and unknown codes
      endcase
    end
  end

  // Branches and SW leave the register file alone
  always_comb
  begin
    case (op1)
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE, OP1_SW : wr_reg_n = 1'b0;
      default : wr_reg_n = 1'b1;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      alu_valid  <= 1'b0;
      alu_wr_reg <= 1'b0;
    end
    else
    begin
      alu_valid  <= in_valid;
      alu_wr_reg <= in_valid && wr_reg_n;  // Bubbles never write
    end
  end

  // Result payload, qualified downstream by alu_valid
  always_ff @(posedge clk)
  begin
    alu_result <= result_n;
  end

endmodule

// File: design/branch_unit.sv
`timescale 1ns/10ps

module branch_unit
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  op1_t  op1,
  input  imm_t  imm,
  input  data_t rs_val,
  input  data_t rt_val,
  input  data_t pc,
  output logic  br_redirect,
  output data_t br_target,
  output logic  br_link_valid
);

  data_t imm_x4;    // Word offset scaled to bytes
  data_t target_n;
  logic  is_jal;
  logic  taken;     // Branch condition holds

  assign imm_x4 = {{(DATA_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm} <<< 2;
  assign is_jal = (op1 == OP1_JAL);

  // Signed compares on the two register values
  always_comb
  begin
    case (op1)
      OP1_BEQ : taken = (rs_val == rt_val);
      OP1_BLT : taken = (rs_val < rt_val);
      OP1_BLE : taken = (rs_val <= rt_val);
      OP1_BNE : taken = (rs_val != rt_val);
      default : taken = 1'b0;
    endcase
  end

  // JAL is register relative, branches are PC relative past the slot
  assign target_n = is_jal ? rs_val + imm_x4 : pc + INST_STEP + imm_x4;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      br_redirect   <= 1'b0;
      br_link_valid <= 1'b0;
    end
    else
    begin
      br_redirect   <= in_valid && (is_jal || taken);
      br_link_valid <= in_valid && is_jal;  // Only JAL writes a link
    end
  end

  // Target only matters while br_redirect is high
  always_ff @(posedge clk)
  begin
    br_target <= target_n;
  end

endmodule

// File: design/core_pkg.sv
package core_pkg;

  // Datapath width
  localparam int DATA_BITS = 32;

  // Operands, results and PCs all share this word
  typedef logic signed [DATA_BITS-1:0] data_t;

  // Byte distance between consecutive instructions
  localparam data_t INST_STEP = data_t'(4);

endpackage

// File: design/exec_stage.sv
`timescale 1ns/10ps

module exec_stage
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  op1_t  op1,
  input  op2_t  op2,
  input  imm_t  imm,
  input  data_t rs_val,
  input  data_t rt_val,
  input  data_t pc,
  output logic  out_valid,
  output data_t result,
  output logic  wr_reg,
  output logic  redirect,
  output data_t redirect_pc
);

  // First stage to writeback
  logic  alu_valid;
  data_t alu_result;
  logic  alu_wr_reg;
  logic  br_redirect;
  data_t br_target;
  logic  br_link_valid;

  alu_unit u_alu (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .op1        (op1),
    .op2        (op2),
    .imm        (imm),
    .rs_val     (rs_val),
    .rt_val     (rt_val),
    .alu_valid  (alu_valid),
    .alu_result (alu_result),
    .alu_wr_reg (alu_wr_reg)
  );

  // Runs beside the ALU on the same operands
  branch_unit u_branch (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .op1           (op1),
    .imm           (imm),
    .rs_val        (rs_val),
    .rt_val        (rt_val),
    .pc            (pc),
    .br_redirect   (br_redirect),
    .br_target     (br_target),
    .br_link_valid (br_link_valid)
  );

  exec_writeback u_wb (
    .clk           (clk),
    .reset         (reset),
    .alu_valid     (alu_valid),
    .alu_result    (alu_result),
    .alu_wr_reg    (alu_wr_reg),
    .br_redirect   (br_redirect),
    .br_target     (br_target),
    .br_link_valid (br_link_valid),
    .pc_d          (pc),           // Delayed inside the writeback
    .out_valid     (out_valid),
    .result        (result),
    .wr_reg        (wr_reg),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

endmodule

// File: design/exec_writeback.sv
`timescale 1ns/10ps

module exec_writeback
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  alu_valid,
  input  data_t alu_result,
  input  logic  alu_wr_reg,
  input  logic  br_redirect,
  input  data_t br_target,
  input  logic  br_link_valid,
  input  data_t pc_d,         // D side of the PC delay flop
  output logic  out_valid,
  output data_t result,
  output logic  wr_reg,
  output logic  redirect,
  output data_t redirect_pc
);

  data_t pc_q;        // PC of the item now in the unit registers
  data_t result_n;
  logic  squash;      // Previous item left with a redirect
  logic  live;        // Item present and not squashed
  logic  redirect_n;

  always_ff @(posedge clk)
  begin
    pc_q <= pc_d;
  end

  assign live       = alu_valid && !squash;
  assign redirect_n = br_redirect && !squash;
  // JAL returns the address after itself
  assign result_n   = br_link_valid ? pc_q + INST_STEP : alu_result;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      squash      <= 1'b0;
      out_valid   <= 1'b0;
      result      <= '0;
      wr_reg      <= 1'b0;
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end
    else
    begin
      squash      <= redirect_n;  // Kills only the very next cycle
      out_valid   <= live;
      result      <= live ? result_n : '0;
      wr_reg      <= live && alu_wr_reg;
      redirect    <= redirect_n;  // One-cycle pulse
      redirect_pc <= redirect_n ? br_target : '0;
    end
  end

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

  // Instruction field widths
  localparam int OP1_BITS = 6;
  localparam int OP2_BITS = 8;
  localparam int IMM_BITS = 16;

  // Raw immediate field as issued
  typedef logic [IMM_BITS-1:0] imm_t;

  // Primary opcodes
  typedef enum logic [OP1_BITS-1:0] {
    OP1_ALUR = 6'b000000,  // Register ops, selected by op2
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,  // Jump to rs + 4*imm, link pc + 4
    OP1_LW   = 6'b010010,  // Only the address add remains
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_t;

  // Secondary opcodes, only meaningful with OP1_ALUR
  typedef enum logic [OP2_BITS-1:0] {
    OP2_EQ   = 8'b00001000,  // Compares give 0 or 1
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,  // Arithmetic
    OP2_LSHF = 8'b00110001   // Logical
  } op2_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec -f vlog.f
./obj_dir/Vtb_exec +verilator+error+limit+100 2>&1 | tee sim.log

if grep -qx "NO ERRORS" sim.log
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: testbench/exec_assert.sv
`timescale 1ns/10ps

module exec_assert (
  input logic clk,
  input logic reset,
  input logic out_valid,
  input logic wr_reg,
  input logic redirect
);

  int fail_count = 0;  // Read by the testbench summary

  // Slot after a redirect is always squashed
  redirect_gap: assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
    else
    begin
      $error("redirect high on two consecutive cycles");
      fail_count = fail_count + 1;
    end

  quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !out_valid)
    else
    begin
      $error("out_valid high while reset is asserted");
      fail_count = fail_count + 1;
    end

  // A write needs a live item
  write_needs_valid: assert property (@(posedge clk) disable iff (reset) wr_reg |-> out_valid)
    else
    begin
      $error("wr_reg high without out_valid");
      fail_count = fail_count + 1;
    end

endmodule

// File: testbench/exec_checker.sv
`timescale 1ns/10ps

module exec_checker
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  int    test_id,
  input  logic  exp_out_valid,
  input  data_t exp_result,
  input  logic  exp_wr_reg,
  input  logic  exp_redirect,
  input  data_t exp_redirect_pc,
  input  logic  out_valid,
  input  data_t result,
  input  logic  wr_reg,
  input  logic  redirect,
  input  data_t redirect_pc,
  output int    pass_count,
  output int    fail_count,
  output int    stray_count
);

  typedef struct packed {
    int    id;
    logic  out_valid;
    data_t result;
    logic  wr_reg;
    logic  redirect;
    data_t redirect_pc;
  } expect_t;

  expect_t exp_q[$];  // Items in flight with the oldest first
  logic    seen_d1;   // Strobe seen one negedge ago
  logic    seen_d2;   // Item now at the outputs

  task automatic check_field(input string name, input int id, input data_t got,
                             input data_t exp, inout int bad);
    if (got !== exp)
    begin
      $display("Mismatch at %0d ns: test %0d %s is %h, expected %h", $time, id, name, got, exp);
      bad = bad + 1;
    end
  endtask

  task automatic compare_item();
    expect_t e;
    int      bad;
    bad = 0;
    e = exp_q.pop_front();
    check_field("out_valid", e.id, data_t'(out_valid), data_t'(e.out_valid), bad);
    check_field("result", e.id, result, e.result, bad);
    check_field("wr_reg", e.id, data_t'(wr_reg), data_t'(e.wr_reg), bad);
    check_field("redirect", e.id, data_t'(redirect), data_t'(e.redirect), bad);
    check_field("redirect_pc", e.id, redirect_pc, e.redirect_pc, bad);
    if (bad == 0)
    begin
      $display("Test %0d passed at %0d ns", e.id, $time);
      pass_count = pass_count + 1;
    end
    else
    begin
      $display("Test %0d failed with %0d wrong fields", e.id, bad);
      fail_count = fail_count + 1;
    end
  endtask

  // Outputs are stable by the falling edge
  always @(negedge clk)
  begin
    if (reset)
    begin
      seen_d1     = 1'b0;
      seen_d2     = 1'b0;
      pass_count  = 0;
      fail_count  = 0;
      stray_count = 0;
      exp_q.delete();
    end
    else
    begin
      if (seen_d2)
        compare_item();  // Two edges after its strobe
      else if (out_valid || wr_reg || redirect)
      begin
        $display("Output activity at %0d ns with no instruction in flight", $time);
        stray_count = stray_count + 1;
      end
      seen_d2 = seen_d1;
      seen_d1 = in_valid;
      if (in_valid)
        exp_q.push_back({test_id, exp_out_valid, exp_result, exp_wr_reg, exp_redirect,
                         exp_redirect_pc});
    end
  end

endmodule

// File: testbench/exec_testdata.txt
# gap op1 op2 imm rs_val rt_val pc | out_valid result wr_reg redirect redirect_pc, all hex
# gap is the count of idle cycles before the strobe, op1 and op2 use the isa_pkg codes
3 00 08 0000 00000005 00000005 00000100 1 00000001 1 0 00000000
0 00 09 0000 fffffffe 00000003 00000104 1 00000001 1 0 00000000
0 00 0a 0000 00000007 fffffff0 00000108 1 00000000 1 0 00000000
0 00 0b 0000 00000001 00000001 0000010c 1 00000000 1 0 00000000
0 00 20 0000 7fffffff 00000001 00000110 1 80000000 1 0 00000000
0 00 24 0000 f0f0f0f0 0ff00ff0 00000114 1 00f000f0 1 0 00000000
0 00 25 0000 f0f0f0f0 0ff00ff0 00000118 1 fff0fff0 1 0 00000000
0 00 26 0000 f0f0f0f0 0ff00ff0 0000011c 1 ff00ff00 1 0 00000000
0 00 28 0000 00000003 00000005 00000120 1 fffffffe 1 0 00000000
0 00 2c 0000 f0f0f0f0 0ff00ff0 00000124 1 ff0fff0f 1 0 00000000
0 00 2d 0000 f0f0f0f0 0ff00ff0 00000128 1 000f000f 1 0 00000000
0 00 2e 0000 f0f0f0f0 0ff00ff0 0000012c 1 00ff00ff 1 0 00000000
0 00 30 0000 80000010 00000004 00000130 1 f8000001 1 0 00000000
0 00 31 0000 80000011 00000004 00000134 1 00000110 1 0 00000000
0 20 00 fffc 00000010 00000000 00000138 1 0000000c 1 0 00000000
0 24 00 8001 ffffffff 00000000 0000013c 1 ffff8001 1 0 00000000
0 25 00 1234 00000000 00000000 00000140 1 00001234 1 0 00000000
0 26 00 ff00 0000ffff 00000000 00000144 1 ffff00ff 1 0 00000000
0 12 00 0010 00001000 00000000 00000148 1 00001010 1 0 00000000
0 1a 00 fff0 00001000 00000000 0000014c 1 00000ff0 0 0 00000000
0 08 00 0004 00000003 00000003 00000200 1 00000000 0 1 00000214
1 08 00 0004 00000003 00000004 00000204 1 00000000 0 0 00000000
0 09 00 fffe fffffff0 00000001 00000300 1 00000000 0 1 000002fc
1 09 00 fffe 00000005 fffffff0 00000304 1 00000000 0 0 00000000
0 0a 00 0001 00000005 00000005 00000400 1 00000000 0 1 00000408
1 0a 00 0001 00000006 00000005 00000404 1 00000000 0 0 00000000
0 0b 00 0010 00000001 00000002 00000500 1 00000000 0 1 00000544
1 0b 00 0010 00000007 00000007 00000504 1 00000000 0 0 00000000
0 0c 00 0008 00002000 00000000 00000600 1 00000604 1 1 00002020
1 08 00 0002 00000000 00000000 00000700 1 00000000 0 1 0000070c
0 20 00 0001 00000001 00000000 00000704 0 00000000 0 0 00000000
1 20 00 0001 00000001 00000000 00000704 1 00000002 1 0 00000000

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic reset
);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Held for four rising edges, released on the fourth
  initial
  begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: testbench/tb_exec.sv
`timescale 1ns/10ps

module tb_exec
  import isa_pkg::*;
  import core_pkg::*;
();

  // One testdata line
  typedef struct packed {
    int    gap;
    op1_t  op1;
    op2_t  op2;
    imm_t  imm;
    data_t rs_val;
    data_t rt_val;
    data_t pc;
    logic  out_valid;
    data_t result;
    logic  wr_reg;
    logic  redirect;
    data_t redirect_pc;
  } vector_t;

  logic    clk;
  logic    reset;
  logic    in_valid;
  op1_t    op1;
  op2_t    op2;
  imm_t    imm;
  data_t   rs_val;
  data_t   rt_val;
  data_t   pc;
  logic    out_valid;
  data_t   result;
  logic    wr_reg;
  logic    redirect;
  data_t   redirect_pc;
  int      test_id;         // Travels beside the strobe
  logic    exp_out_valid;
  data_t   exp_result;
  logic    exp_wr_reg;
  logic    exp_redirect;
  data_t   exp_redirect_pc;
  int      pass_count;
  int      fail_count;
  int      stray_count;
  vector_t vec_q[$];
  bit      load_failed;

  tb_clock clk_gen (.clk(clk), .reset(reset));

  exec_stage dut0 (.*);

  exec_checker chk0 (.*);

  bind exec_stage exec_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .wr_reg    (wr_reg),
    .redirect  (redirect)
  );

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [12];
    vector_t     v;
    fd = $fopen("testbench/exec_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open testbench/exec_testdata.txt");
      load_failed = 1'b1;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#")  // Skip column notes
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n == 12)
        begin
          v.gap         = f[0];
          v.op1         = op1_t'(f[1][5:0]);
          v.op2         = op2_t'(f[2][7:0]);
          v.imm         = f[3][15:0];
          v.rs_val      = f[4];
          v.rt_val      = f[5];
          v.pc          = f[6];
          v.out_valid   = f[7][0];
          v.result      = f[8];
          v.wr_reg      = f[9][0];
          v.redirect    = f[10][0];
          v.redirect_pc = f[11];
          vec_q.push_back(v);
        end
        else if (n > 0)
        begin
          $display("Testdata line has %0d fields instead of 12", n);
          load_failed = 1'b1;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_cycles(input int n);
    int k;
    for (k = 0; k < n; k++)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // One instruction plus its expected fields
  task automatic drive_vector(input vector_t v, input int id);
    @(posedge clk);
    in_valid        <= 1'b1;
    op1             <= v.op1;
    op2             <= v.op2;
    imm             <= v.imm;
    rs_val          <= v.rs_val;
    rt_val          <= v.rt_val;
    pc              <= v.pc;
    test_id         <= id;
    exp_out_valid   <= v.out_valid;
    exp_result      <= v.result;
    exp_wr_reg      <= v.wr_reg;
    exp_redirect    <= v.redirect;
    exp_redirect_pc <= v.redirect_pc;
  endtask

  initial
  begin
    int cycles;
    int total;
    int assert_fails;
    bit timed_out;
    timed_out       = 1'b0;
    load_failed     = 1'b0;
    in_valid        = 1'b0;
    op1             = OP1_ALUR;
    op2             = OP2_ADD;
    imm             = '0;
    rs_val          = '0;
    rt_val          = '0;
    pc              = '0;
    test_id         = 0;
    exp_out_valid   = 1'b0;
    exp_result      = '0;
    exp_wr_reg      = 1'b0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = '0;
    load_vectors();
    total = vec_q.size();
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (reset !== 1'b0 && cycles < 20);
    if (reset !== 1'b0)
    begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
    else
    begin
      foreach (vec_q[i])
      begin
        idle_cycles(vec_q[i].gap);
        drive_vector(vec_q[i], i);
      end
      idle_cycles(1);
      cycles = 0;
      while (pass_count + fail_count < total && cycles < 20)
      begin
        @(posedge clk);
        cycles++;
      end
      if (pass_count + fail_count < total)
      begin
        $display("Timeout: only %0d of %0d tests produced a result",
                 pass_count + fail_count, total);
        timed_out = 1'b1;
      end
    end
    assert_fails = dut0.u_assert.fail_count;
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d stray, %0d assertion failures",
             total, pass_count, fail_count, stray_count, assert_fails);
    if (!load_failed && !timed_out && total > 0 && fail_count == 0 && stray_count == 0
        && assert_fails == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/isa_pkg.sv
design/core_pkg.sv
design/alu_unit.sv
design/branch_unit.sv
design/exec_writeback.sv
design/exec_stage.sv
testbench/tb_clock.sv
testbench/exec_checker.sv
testbench/exec_assert.sv
testbench/tb_exec.sv
